/* common/axi_proto_pkg.sv */
package axi_proto_pkg;

    // bus widths shared by every channel.
    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 8;
    localparam int STRB_W = DATA_W / 8; // one strobe bit per data byte.

    // burst kinds as coded on AxBURST.
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_t;

    // only the two responses this slave can give are listed.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

endpackage

/* common/axi_chan_pkg.sv */
package axi_chan_pkg;

    // write and read address channels carry the same fields.
    typedef struct packed {
        logic [axi_proto_pkg::ID_W-1:0]   id;
        logic [axi_proto_pkg::ADDR_W-1:0] addr;
        logic [axi_proto_pkg::LEN_W-1:0]  len;   // beats minus one.
        axi_proto_pkg::burst_t            burst;
    } aw_chan_t;

    typedef struct packed {
        logic [axi_proto_pkg::ID_W-1:0]   id;
        logic [axi_proto_pkg::ADDR_W-1:0] addr;
        logic [axi_proto_pkg::LEN_W-1:0]  len;
        axi_proto_pkg::burst_t            burst;
    } ar_chan_t;

    typedef struct packed {
        logic [axi_proto_pkg::DATA_W-1:0] data;
        logic [axi_proto_pkg::STRB_W-1:0] strb;
        logic                             last;
    } w_chan_t;

    typedef struct packed {
        logic [axi_proto_pkg::ID_W-1:0] id;
        axi_proto_pkg::resp_t           resp;
    } b_chan_t;

    typedef struct packed {
        logic [axi_proto_pkg::ID_W-1:0]   id;
        logic [axi_proto_pkg::DATA_W-1:0] data;
        axi_proto_pkg::resp_t             resp;
        logic                             last;
    } r_chan_t;

endpackage

/* slave_axi_async/async_fifo.sv */
module async_fifo #(
    parameter int  FIFO_DEPTH_LOG2 = 3,
    parameter type payload_t       = logic
) (
    input  logic     wr_clk,
    input  logic     wr_rstn,
    input  logic     wr_en,
    input  payload_t wr_data,
    output logic     full,
    input  logic     rd_clk,
    input  logic     rd_rstn,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty
);
    localparam int AW = FIFO_DEPTH_LOG2;

    payload_t mem [2**AW];

    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray;
    logic [AW:0] rd_gray_s1;
    logic [AW:0] rd_gray_s2;
    logic [AW:0] rd_bin_s;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray;
    logic [AW:0] wr_gray_s1;
    logic [AW:0] wr_gray_s2;
    logic        wr_push;
    logic        rd_pop;

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    assign wr_push     = wr_en && !full;
    assign wr_bin_next = wr_bin + {{AW{1'b0}}, wr_push};

    always_ff @(posedge wr_clk) begin
        if (!wr_rstn) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) mem[wr_bin[AW-1:0]] <= wr_data;
    end

    // full when the pointers differ only in the wrap bit.
    assign rd_bin_s = gray2bin(rd_gray_s2);
    assign full     = (wr_bin ^ rd_bin_s) == {1'b1, {AW{1'b0}}};

    assign rd_pop      = rd_en && !empty;
    assign rd_bin_next = rd_bin + {{AW{1'b0}}, rd_pop};

    always_ff @(posedge rd_clk) begin
        if (!rd_rstn) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_pop) rd_data <= mem[rd_bin[AW-1:0]]; // word for the output stage.
    end

    assign empty = (rd_gray == wr_gray_s2);

endmodule

/* slave_axi_async/cdc_channel.sv */
module cdc_channel #(
    parameter int  FIFO_DEPTH_LOG2 = 3,
    parameter type payload_t       = logic
) (
    input  logic     src_clk,
    input  logic     src_rstn,
    input  logic     dst_clk,
    input  logic     dst_rstn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic rst_released;
    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;
    logic out_xfer;
    logic empty_out;

    assign rst_released = src_rstn && dst_rstn;
    assign in_ready     = rst_released && !full;
    assign wr_en        = in_valid && in_ready;

    // the output stage is refilled when it is empty or its word is taken.
    assign out_xfer  = out_valid && out_ready;
    assign rd_en     = !empty && (empty_out || out_xfer);
    assign out_valid = rst_released && !empty_out;

    always_ff @(posedge dst_clk) begin
        if (!dst_rstn) begin
            empty_out <= 1'b1;
        end else if (empty && out_xfer) begin
            empty_out <= 1'b1;
        end else if (rd_en && empty_out) begin
            empty_out <= 1'b0;
        end
    end

    async_fifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
        .payload_t      (payload_t)
    ) u_fifo (
        .wr_clk (src_clk),  .wr_rstn(src_rstn), .wr_en(wr_en), .wr_data(in_data),
        .full   (full),
        .rd_clk (dst_clk),  .rd_rstn(dst_rstn), .rd_en(rd_en), .rd_data(out_data),
        .empty  (empty)
    );

endmodule

/* slave_axi_async/slave_axi_async.sv */
module slave_axi_async #(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RSTN,
    input  logic                   SLAVE_CLK,
    input  logic                   SLAVE_RSTN,
    input  axi_chan_pkg::aw_chan_t bus_aw,
    input  logic                   bus_aw_valid,
    output logic                   bus_aw_ready,
    output axi_chan_pkg::aw_chan_t slave_aw,
    output logic                   slave_aw_valid,
    input  logic                   slave_aw_ready,
    input  axi_chan_pkg::w_chan_t  bus_w,
    input  logic                   bus_w_valid,
    output logic                   bus_w_ready,
    output axi_chan_pkg::w_chan_t  slave_w,
    output logic                   slave_w_valid,
    input  logic                   slave_w_ready,
    input  axi_chan_pkg::ar_chan_t bus_ar,
    input  logic                   bus_ar_valid,
    output logic                   bus_ar_ready,
    output axi_chan_pkg::ar_chan_t slave_ar,
    output logic                   slave_ar_valid,
    input  logic                   slave_ar_ready,
    output axi_chan_pkg::b_chan_t  bus_b,
    output logic                   bus_b_valid,
    input  logic                   bus_b_ready,
    input  axi_chan_pkg::b_chan_t  slave_b,
    input  logic                   slave_b_valid,
    output logic                   slave_b_ready,
    output axi_chan_pkg::r_chan_t  bus_r,
    output logic                   bus_r_valid,
    input  logic                   bus_r_ready,
    input  axi_chan_pkg::r_chan_t  slave_r,
    input  logic                   slave_r_valid,
    output logic                   slave_r_ready
);
    cdc_channel #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2), .payload_t(axi_chan_pkg::aw_chan_t)
    ) u_aw_cdc (
        .src_clk (BUS_CLK),        .src_rstn (BUS_RSTN),
        .dst_clk (SLAVE_CLK),      .dst_rstn (SLAVE_RSTN),
        .in_valid (bus_aw_valid),  .in_ready (bus_aw_ready),   .in_data (bus_aw),
        .out_valid(slave_aw_valid), .out_ready(slave_aw_ready), .out_data(slave_aw)
    );

    cdc_channel #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2), .payload_t(axi_chan_pkg::w_chan_t)
    ) u_w_cdc (
        .src_clk (BUS_CLK),        .src_rstn (BUS_RSTN),
        .dst_clk (SLAVE_CLK),      .dst_rstn (SLAVE_RSTN),
        .in_valid (bus_w_valid),   .in_ready (bus_w_ready),    .in_data (bus_w),
        .out_valid(slave_w_valid), .out_ready(slave_w_ready),  .out_data(slave_w)
    );

    cdc_channel #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2), .payload_t(axi_chan_pkg::ar_chan_t)
    ) u_ar_cdc (
        .src_clk (BUS_CLK),        .src_rstn (BUS_RSTN),
        .dst_clk (SLAVE_CLK),      .dst_rstn (SLAVE_RSTN),
        .in_valid (bus_ar_valid),  .in_ready (bus_ar_ready),   .in_data (bus_ar),
        .out_valid(slave_ar_valid), .out_ready(slave_ar_ready), .out_data(slave_ar)
    );

    // the response channels start on the slave clock and end on the bus clock.
    cdc_channel #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2), .payload_t(axi_chan_pkg::b_chan_t)
    ) u_b_cdc (
        .src_clk (SLAVE_CLK),      .src_rstn (SLAVE_RSTN),
        .dst_clk (BUS_CLK),        .dst_rstn (BUS_RSTN),
        .in_valid (slave_b_valid), .in_ready (slave_b_ready),  .in_data (slave_b),
        .out_valid(bus_b_valid),   .out_ready(bus_b_ready),    .out_data(bus_b)
    );

    cdc_channel #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2), .payload_t(axi_chan_pkg::r_chan_t)
    ) u_r_cdc (
        .src_clk (SLAVE_CLK),      .src_rstn (SLAVE_RSTN),
        .dst_clk (BUS_CLK),        .dst_rstn (BUS_RSTN),
        .in_valid (slave_r_valid), .in_ready (slave_r_ready),  .in_data (slave_r),
        .out_valid(bus_r_valid),   .out_ready(bus_r_ready),    .out_data(bus_r)
    );

endmodule

/* rtl/axi_slave_ram.sv */
module axi_slave_ram #(
    parameter int MEM_WORDS_LOG2 = 8
) (
    input  logic                   SLAVE_CLK,
    input  logic                   SLAVE_RSTN,
    input  axi_chan_pkg::aw_chan_t aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_chan_pkg::w_chan_t  w,
    input  logic                   w_valid,
    output logic                   w_ready,
    input  axi_chan_pkg::ar_chan_t ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi_chan_pkg::b_chan_t  b,
    output logic                   b_valid,
    input  logic                   b_ready,
    output axi_chan_pkg::r_chan_t  r,
    output logic                   r_valid,
    input  logic                   r_ready
);
    localparam logic [axi_proto_pkg::ADDR_W-1:0] BEAT_BYTES = axi_proto_pkg::DATA_W / 8;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

    logic [axi_proto_pkg::DATA_W-1:0] mem [2**MEM_WORDS_LOG2];

    wr_state_t                        wr_state;
    logic [axi_proto_pkg::ID_W-1:0]   wr_id;
    logic [axi_proto_pkg::ADDR_W-1:0] wr_addr;
    axi_proto_pkg::burst_t            wr_burst;
    logic                             wr_err;
    logic                             wr_ok;
    logic [MEM_WORDS_LOG2-1:0]        wr_idx;

    rd_state_t                        rd_state;
    logic [axi_proto_pkg::ID_W-1:0]   rd_id;
    logic [axi_proto_pkg::ADDR_W-1:0] rd_addr;
    axi_proto_pkg::burst_t            rd_burst;
    logic [axi_proto_pkg::LEN_W-1:0]  rd_cnt;
    logic                             rd_err;
    logic [MEM_WORDS_LOG2-1:0]        rd_idx;

    // a word address is valid when no bit above the array index is set.
    function automatic logic in_range(input logic [axi_proto_pkg::ADDR_W-1:0] addr);
        return addr[axi_proto_pkg::ADDR_W-1:MEM_WORDS_LOG2+2] == '0;
    endfunction

    assign aw_ready = (wr_state == WR_IDLE);
    assign w_ready  = (wr_state == WR_DATA);
    assign b_valid  = (wr_state == WR_RESP); // one clock after the last beat.
    assign wr_idx   = wr_addr[MEM_WORDS_LOG2+1:2];
    assign wr_ok    = in_range(wr_addr) && (wr_burst != axi_proto_pkg::WRAP);

    always_comb begin
        b.id   = wr_id;
        b.resp = wr_err ? axi_proto_pkg::SLVERR : axi_proto_pkg::OKAY;
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: if (aw_valid) wr_state <= WR_DATA;
                WR_DATA: if (w_valid && w.last) wr_state <= WR_RESP;
                WR_RESP: if (b_ready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (aw_valid && aw_ready) begin
            wr_id    <= aw.id;
            wr_addr  <= aw.addr;
            wr_burst <= aw.burst;
            wr_err   <= (aw.burst == axi_proto_pkg::WRAP);
        end else if (w_valid && w_ready) begin
            if (!wr_ok) wr_err <= 1'b1;
            if (wr_burst == axi_proto_pkg::INCR) wr_addr <= wr_addr + BEAT_BYTES;
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (w_valid && w_ready && wr_ok) begin
            for (int i = 0; i < axi_proto_pkg::STRB_W; i++) begin
                if (w.strb[i]) mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

    assign ar_ready = (rd_state == RD_IDLE);
    assign r_valid  = (rd_state == RD_DATA);
    assign rd_idx   = rd_addr[MEM_WORDS_LOG2+1:2];
    assign rd_err   = !in_range(rd_addr) || (rd_burst == axi_proto_pkg::WRAP);

    // failed beats return zero data.
    always_comb begin
        r.id   = rd_id;
        r.data = rd_err ? '0 : mem[rd_idx];
        r.resp = rd_err ? axi_proto_pkg::SLVERR : axi_proto_pkg::OKAY;
        r.last = (rd_cnt == '0);
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (ar_valid) rd_state <= RD_DATA;
                RD_DATA: if (r_ready && r.last) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (ar_valid && ar_ready) begin
            rd_id    <= ar.id;
            rd_addr  <= ar.addr;
            rd_burst <= ar.burst;
            rd_cnt   <= ar.len; // counts down to the last beat.
        end else if (r_valid && r_ready) begin
            rd_cnt <= rd_cnt - 1'b1;
            if (rd_burst == axi_proto_pkg::INCR) rd_addr <= rd_addr + BEAT_BYTES;
        end
    end

endmodule

/* rtl/slave_axi_subsystem.sv */
module slave_axi_subsystem #(
    parameter int FIFO_DEPTH_LOG2 = 3,
    parameter int MEM_WORDS_LOG2  = 8
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RSTN,
    input  logic                   SLAVE_CLK,
    input  logic                   SLAVE_RSTN,
    input  axi_chan_pkg::aw_chan_t bus_aw,
    input  logic                   bus_aw_valid,
    output logic                   bus_aw_ready,
    input  axi_chan_pkg::w_chan_t  bus_w,
    input  logic                   bus_w_valid,
    output logic                   bus_w_ready,
    input  axi_chan_pkg::ar_chan_t bus_ar,
    input  logic                   bus_ar_valid,
    output logic                   bus_ar_ready,
    output axi_chan_pkg::b_chan_t  bus_b,
    output logic                   bus_b_valid,
    input  logic                   bus_b_ready,
    output axi_chan_pkg::r_chan_t  bus_r,
    output logic                   bus_r_valid,
    input  logic                   bus_r_ready
);
    axi_chan_pkg::aw_chan_t slave_aw;
    axi_chan_pkg::w_chan_t  slave_w;
    axi_chan_pkg::ar_chan_t slave_ar;
    axi_chan_pkg::b_chan_t  slave_b;
    axi_chan_pkg::r_chan_t  slave_r;
    logic slave_aw_valid;
    logic slave_aw_ready;
    logic slave_w_valid;
    logic slave_w_ready;
    logic slave_ar_valid;
    logic slave_ar_ready;
    logic slave_b_valid;
    logic slave_b_ready;
    logic slave_r_valid;
    logic slave_r_ready;

    slave_axi_async #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_async (
        .BUS_CLK   (BUS_CLK),   .BUS_RSTN  (BUS_RSTN),
        .SLAVE_CLK (SLAVE_CLK), .SLAVE_RSTN(SLAVE_RSTN),
        .bus_aw  (bus_aw),   .bus_aw_valid  (bus_aw_valid),   .bus_aw_ready  (bus_aw_ready),
        .slave_aw(slave_aw), .slave_aw_valid(slave_aw_valid), .slave_aw_ready(slave_aw_ready),
        .bus_w   (bus_w),    .bus_w_valid   (bus_w_valid),    .bus_w_ready   (bus_w_ready),
        .slave_w (slave_w),  .slave_w_valid (slave_w_valid),  .slave_w_ready (slave_w_ready),
        .bus_ar  (bus_ar),   .bus_ar_valid  (bus_ar_valid),   .bus_ar_ready  (bus_ar_ready),
        .slave_ar(slave_ar), .slave_ar_valid(slave_ar_valid), .slave_ar_ready(slave_ar_ready),
        .bus_b   (bus_b),    .bus_b_valid   (bus_b_valid),    .bus_b_ready   (bus_b_ready),
        .slave_b (slave_b),  .slave_b_valid (slave_b_valid),  .slave_b_ready (slave_b_ready),
        .bus_r   (bus_r),    .bus_r_valid   (bus_r_valid),    .bus_r_ready   (bus_r_ready),
        .slave_r (slave_r),  .slave_r_valid (slave_r_valid),  .slave_r_ready (slave_r_ready)
    );

    axi_slave_ram #(.MEM_WORDS_LOG2(MEM_WORDS_LOG2)) u_ram (
        .SLAVE_CLK (SLAVE_CLK), .SLAVE_RSTN(SLAVE_RSTN),
        .aw(slave_aw), .aw_valid(slave_aw_valid), .aw_ready(slave_aw_ready),
        .w (slave_w),  .w_valid (slave_w_valid),  .w_ready (slave_w_ready),
        .ar(slave_ar), .ar_valid(slave_ar_valid), .ar_ready(slave_ar_ready),
        .b (slave_b),  .b_valid (slave_b_valid),  .b_ready (slave_b_ready),
        .r (slave_r),  .r_valid (slave_r_valid),  .r_ready (slave_r_ready)
    );

endmodule

/* sim/axi_checker.sv */
module axi_checker (
    input logic                  BUS_CLK,
    input logic                  BUS_RSTN,
    input axi_chan_pkg::b_chan_t bus_b,
    input logic                  bus_b_valid,
    input logic                  bus_b_ready,
    input axi_chan_pkg::r_chan_t bus_r,
    input logic                  bus_r_valid,
    input logic                  bus_r_ready
);
    axi_chan_pkg::b_chan_t exp_b [$];
    axi_chan_pkg::r_chan_t exp_r [$];
    axi_chan_pkg::b_chan_t want_b;
    axi_chan_pkg::r_chan_t want_r;
    int errors       = 0;
    int checks       = 0;
    int test_errors  = 0;
    int test_checks  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    task automatic expect_b(input axi_chan_pkg::b_chan_t item);
        exp_b.push_back(item);
    endtask

    task automatic expect_r(input axi_chan_pkg::r_chan_t item);
        exp_r.push_back(item);
    endtask

    function automatic int pending();
        return exp_b.size() + exp_r.size();
    endfunction

    task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
        checks++;
        test_checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("Fail at time %0t: %s expected %0h, got %0h", $time, name, want, got);
        end
    endtask

    task automatic note_error(input string what);
        errors++;
        test_errors++;
        $display("Error at time %0t: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("test %s: %s, %0d checks, %0d errors", name,
                 (test_errors == 0) ? "passed" : "FAILED", test_checks, test_errors);
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic report();
        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
    endtask

    // responses are compared in arrival order, which the bridge must keep.
    always @(posedge BUS_CLK) begin
        if (BUS_RSTN && bus_b_valid && bus_b_ready) begin
            if (exp_b.size() == 0) begin
                note_error("a write response arrived with no write outstanding");
            end else begin
                want_b = exp_b.pop_front();
                compare("bus_b.id", 64'(want_b.id), 64'(bus_b.id));
                compare("bus_b.resp", 64'(want_b.resp), 64'(bus_b.resp));
            end
        end
        if (BUS_RSTN && bus_r_valid && bus_r_ready) begin
            if (exp_r.size() == 0) begin
                note_error("a read beat arrived with no read outstanding");
            end else begin
                want_r = exp_r.pop_front();
                compare("bus_r.id", 64'(want_r.id), 64'(bus_r.id));
                compare("bus_r.data", 64'(want_r.data), 64'(bus_r.data));
                compare("bus_r.resp", 64'(want_r.resp), 64'(bus_r.resp));
                compare("bus_r.last", 64'(want_r.last), 64'(bus_r.last));
            end
        end
    end

endmodule

/* sim/tb_slave_axi_subsystem.sv */
module tb_slave_axi_subsystem;
    localparam int          MEM_WORDS_LOG2 = 8;
    localparam int          MEM_WORDS      = 2 ** MEM_WORDS_LOG2;
    localparam logic [31:0] SEED           = 32'he5ff1a60;

    logic BUS_CLK, BUS_RSTN, SLAVE_CLK, SLAVE_RSTN;
    axi_chan_pkg::aw_chan_t bus_aw;
    axi_chan_pkg::w_chan_t  bus_w;
    axi_chan_pkg::ar_chan_t bus_ar;
    axi_chan_pkg::b_chan_t  bus_b;
    axi_chan_pkg::r_chan_t  bus_r;
    logic bus_aw_valid, bus_aw_ready, bus_w_valid, bus_w_ready, bus_ar_valid, bus_ar_ready;
    logic bus_b_valid, bus_b_ready, bus_r_valid, bus_r_ready;

    logic [31:0] model [MEM_WORDS]; // reference copy of the RAM contents.
    logic [31:0] rng          = SEED;
    logic [31:0] gap_rng      = SEED;
    logic        gaps_on      = 1'b0;
    int          beats_issued = 0;
    int          cycles       = 0;
    int          b_hold       = 0;
    int          r_hold       = 0;

    slave_axi_subsystem #(.FIFO_DEPTH_LOG2(3), .MEM_WORDS_LOG2(MEM_WORDS_LOG2)) DUT (.*);
    axi_checker u_check (.*);

    initial begin
        SLAVE_CLK = 1'b0;
        forever #10 SLAVE_CLK = ~SLAVE_CLK;
    end

    initial begin
        BUS_CLK = 1'b0;
        forever #7 BUS_CLK = ~BUS_CLK; // unrelated to the slave clock, so the crossing is real.
    end

    // galois LFSR, stepped once for every bit handed out.
    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    // a beat is served only inside the memory and never for WRAP.
    function automatic logic beat_ok(input logic [31:0] addr, input axi_proto_pkg::burst_t burst);
        return (addr < 32'(4 * MEM_WORDS)) && (burst != axi_proto_pkg::WRAP);
    endfunction

    task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                               input logic [7:0] len, input axi_proto_pkg::burst_t burst,
                               input logic fill);
        axi_chan_pkg::b_chan_t b;
        logic [31:0] a;
        logic [31:0] v;
        logic        err;
        a = addr;
        err = 1'b0;
        beats_issued += int'(len) + 1;
        bus_aw.id    = id;
        bus_aw.addr  = addr;
        bus_aw.len   = len;
        bus_aw.burst = burst;
        bus_aw_valid = 1'b1;
        @(posedge BUS_CLK);
        while (!bus_aw_ready) @(posedge BUS_CLK);
        #2;
        bus_aw_valid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            v           = take_bits(rng, 4);
            bus_w.data  = fill ? fill_word(a) : take_bits(rng, 32);
            bus_w.strb  = fill ? 4'hf : v[3:0];
            bus_w.last  = (i == int'(len));
            bus_w_valid = 1'b1;
            if (!beat_ok(a, burst)) begin
                err = 1'b1;
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (bus_w.strb[k]) begin
                        model[a[MEM_WORDS_LOG2+1:2]][8*k +: 8] = bus_w.data[8*k +: 8];
                    end
                end
            end
            @(posedge BUS_CLK);
            while (!bus_w_ready) @(posedge BUS_CLK);
            #2;
            if (burst == axi_proto_pkg::INCR) a = a + 32'd4;
        end
        bus_w_valid = 1'b0;
        b.id   = id;
        b.resp = err ? axi_proto_pkg::SLVERR : axi_proto_pkg::OKAY;
        u_check.expect_b(b);
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input axi_proto_pkg::burst_t burst);
        axi_chan_pkg::r_chan_t r;
        logic [31:0] a;
        a = addr;
        beats_issued += int'(len) + 1;
        for (int i = 0; i <= int'(len); i++) begin
            r.id   = id;
            r.last = (i == int'(len));
            r.data = beat_ok(a, burst) ? model[a[MEM_WORDS_LOG2+1:2]] : '0;
            r.resp = beat_ok(a, burst) ? axi_proto_pkg::OKAY : axi_proto_pkg::SLVERR;
            u_check.expect_r(r);
            if (burst == axi_proto_pkg::INCR) a = a + 32'd4;
        end
        bus_ar.id    = id;
        bus_ar.addr  = addr;
        bus_ar.len   = len;
        bus_ar.burst = burst;
        bus_ar_valid = 1'b1;
        @(posedge BUS_CLK);
        while (!bus_ar_ready) @(posedge BUS_CLK);
        #2;
        bus_ar_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (u_check.pending() != 0) @(posedge BUS_CLK);
        repeat (4) @(posedge BUS_CLK);
        #2;
    endtask

    // writes a set of INCR bursts, waits for every b, then reads them all back.
    task automatic burst_round(input int count, input int len_bits);
        logic [31:0] addrs [8];
        logic [7:0]  lens [8];
        logic [31:0] v;
        for (int i = 0; i < count; i++) begin
            v        = take_bits(rng, len_bits);
            lens[i]  = v[7:0];
            v        = take_bits(rng, 8) % (MEM_WORDS - int'(lens[i]));
            addrs[i] = v << 2;
            v        = take_bits(rng, 4);
            write_burst(v[3:0], addrs[i], lens[i], axi_proto_pkg::INCR, 1'b0);
        end
        wait_idle();
        for (int i = 0; i < count; i++) begin
            v = take_bits(rng, 4);
            read_burst(v[3:0], addrs[i], lens[i], axi_proto_pkg::INCR);
        end
        wait_idle();
    endtask

    initial begin
        bus_b_ready = 1'b1;
        bus_r_ready = 1'b1;
        forever begin
            @(posedge BUS_CLK);
            #2;
            if (!gaps_on) begin
                bus_b_ready = 1'b1;
                bus_r_ready = 1'b1;
            end else begin
                if (b_hold == 0) begin
                    bus_b_ready = !bus_b_ready;
                    b_hold      = 1 + int'(take_bits(gap_rng, 3)); // length of the next stretch.
                end
                if (r_hold == 0) begin
                    bus_r_ready = !bus_r_ready;
                    r_hold      = 1 + int'(take_bits(gap_rng, 3));
                end
                b_hold--;
                r_hold--;
            end
        end
    end

    always @(posedge BUS_CLK) begin
        cycles++;
        if (cycles > 40 * beats_issued + 500) begin
            $display("timeout after %0d bus cycles: the run hung waiting on the DUT", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] a;
        logic [7:0]  len;
        BUS_RSTN     = 1'b0;
        SLAVE_RSTN   = 1'b0;
        bus_aw       = '0;
        bus_w        = '0;
        bus_ar       = '0;
        bus_aw_valid = 1'b0;
        bus_w_valid  = 1'b0;
        bus_ar_valid = 1'b0;
        repeat (2) @(posedge SLAVE_CLK);
        u_check.compare("bus_aw_ready", 64'd0, 64'(bus_aw_ready));
        u_check.compare("bus_ar_ready", 64'd0, 64'(bus_ar_ready));
        #2;
        SLAVE_RSTN = 1'b1;
        @(posedge BUS_CLK);
        #2;
        BUS_RSTN = 1'b1;
        @(posedge BUS_CLK);
        for (int i = 0; i < 8 && !(bus_aw_ready && bus_ar_ready); i++) @(posedge BUS_CLK);
        u_check.compare("bus_aw_ready", 64'd1, 64'(bus_aw_ready));
        u_check.compare("bus_ar_ready", 64'd1, 64'(bus_ar_ready));
        u_check.compare("bus_b_valid", 64'd0, 64'(bus_b_valid));
        u_check.compare("bus_r_valid", 64'd0, 64'(bus_r_valid));
        #2;
        u_check.end_test("reset");

        // one full-length burst gives every word a known value.
        write_burst(4'h0, 32'h0, 8'(MEM_WORDS - 1), axi_proto_pkg::INCR, 1'b1);
        wait_idle();
        u_check.end_test("fill");

        burst_round(8, 0);
        u_check.end_test("single_beat");
        burst_round(6, 4);
        u_check.end_test("incr_burst");

        v   = take_bits(rng, 3);
        len = 8'(v[2:0]) + 8'd1;
        v   = take_bits(rng, 8);
        a   = {22'd0, v[7:0], 2'b00};
        write_burst(4'h5, a, len, axi_proto_pkg::FIXED, 1'b0);
        wait_idle();
        read_burst(4'h6, a, len, axi_proto_pkg::FIXED);
        wait_idle();
        u_check.end_test("fixed_burst");

        a = 32'(4 * (MEM_WORDS - 4)); // the last four beats fall off the end.
        write_burst(4'h9, a, 8'd7, axi_proto_pkg::INCR, 1'b0);
        write_burst(4'hb, 32'h40, 8'd3, axi_proto_pkg::WRAP, 1'b0);
        wait_idle();
        read_burst(4'ha, a, 8'd7, axi_proto_pkg::INCR);
        read_burst(4'hc, 32'h40, 8'd3, axi_proto_pkg::WRAP);
        read_burst(4'hd, 32'h40, 8'd3, axi_proto_pkg::INCR);
        wait_idle();
        u_check.end_test("error_bursts");

        gaps_on = 1'b1;
        burst_round(8, 4);
        gaps_on = 1'b0;
        u_check.end_test("back_pressure");

        u_check.report();
        if (u_check.errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
common/axi_proto_pkg.sv
common/axi_chan_pkg.sv
slave_axi_async/async_fifo.sv
slave_axi_async/cdc_channel.sv
slave_axi_async/slave_axi_async.sv
rtl/axi_slave_ram.sv
rtl/slave_axi_subsystem.sv
sim/axi_checker.sv
sim/tb_slave_axi_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_slave_axi_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "result: no verdict"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
